//--- Makefile
# build with Verilator, run, and pass only if the pass line shows up

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module decode_tb -f flist.f \
		-Mdir obj_dir -o decode_tb
	out="$$(./obj_dir/decode_tb +verilator+error+limit+100000)"; echo "$$out"; \
		echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

//--- flist.f
verilog/rv_decode_pkg.sv
verilog/imm_gen.sv
verilog/alu_func_dec.sv
verilog/id_stage.sv
verilog/issue_reg.sv
verilog/decode_top.sv
test/decode_asserts.sv
test/decode_tb.sv

//--- test/decode_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module decode_asserts (
	input	logic			clk,
	input	logic			reset,
	input	logic	[31:0]	fetch_pc,
	input	logic	[31:0]	fetch_inst,
	input	logic			fetch_vld,
	input	logic			issue_vld,
	input	logic	[31:0]	issue_pc,
	input	logic	[31:0]	issue_imm,
	input	logic	[4:0]	issue_rs1,
	input	logic	[4:0]	issue_rs2,
	input	logic	[4:0]	issue_rd,
	input	logic	[2:0]	issue_opa_sel,
	input	logic	[2:0]	issue_opb_sel,
	input	logic	[4:0]	issue_alu_func,
	input	logic	[1:0]	issue_mem_cmd
);

	import rv_decode_pkg::*;

	int				fail_count = 0;
	rv_inst_t		fi;
	logic	[5:0]	alu_res;
	logic			known;
	logic			exp_vld;
	logic	[31:0]	exp_imm;
	logic	[4:0]	exp_rd;
	logic	[2:0]	exp_opa;
	logic	[2:0]	exp_opb;
	logic	[1:0]	exp_cmd;
	logic	[4:0]	hist1;
	logic	[4:0]	hist2;
	logic			want_vld;
	logic	[31:0]	want_pc;
	logic	[31:0]	want_imm;
	logic	[4:0]	want_rs1;
	logic	[4:0]	want_rs2;
	logic	[4:0]	want_rd;
	logic	[2:0]	want_opa;
	logic	[2:0]	want_opb;
	logic	[4:0]	want_alu;
	logic	[1:0]	want_cmd;

	function automatic logic [4:0] base_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0: return ALU_ADD;
			3'd1: return ALU_SLL;
			3'd2: return ALU_SLT;
			3'd3: return ALU_SLTU;
			3'd4: return ALU_XOR;
			3'd5: return alt ? ALU_SRA : ALU_SRL;
			3'd6: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	// bit 5 is set when the encoding is a listed one
	function automatic logic [5:0] expect_alu(input rv_inst_t w);
		if (w.r.opcode == OP_I_ARITH)
			return {1'b1, base_op(w.i.funct3, w.r.funct7[5])};
		if (w.r.opcode != OP_R_TYPE)
			return {1'b1, ALU_ADD};
		case (w.r.funct7)
			7'h00: return {1'b1, base_op(w.r.funct3, 1'b0)};
			7'h20: begin
				if (w.r.funct3 == 3'd0)
					return {1'b1, ALU_SUB};
				if (w.r.funct3 == 3'd5)
					return {1'b1, ALU_SRA};
			end
			7'h01: begin
				case (w.r.funct3)
					3'd0: return {1'b1, ALU_MUL};
					3'd1: return {1'b1, ALU_MULH};
					3'd2: return {1'b1, ALU_MULHSU};
					3'd3: return {1'b1, ALU_MULHU};
					default: ;
				endcase
			end
			default: ;
		endcase
		return {1'b0, ALU_ADD};
	endfunction

	function automatic logic [2:0] expect_fwd(input logic [4:0] src);
		if (src == ZERO_REG)
			return SEL_0;
		if (src == hist1)
			return SEL_F1;
		if (src == hist2)
			return SEL_F2;
		return SEL_RS;
	endfunction

	// **************************************************
	// expected decode of the word now at the fetch port
	// **************************************************
	assign fi = fetch_inst;
	assign alu_res = expect_alu(fi);
	assign exp_vld = fetch_vld & known & alu_res[5];

	always_comb begin
		known = 1'b1;
		exp_opa = SEL_0;
		exp_opb = SEL_4;
		exp_cmd = BUS_NONE;
		exp_rd = fi.r.rd;
		exp_imm = {{20{fetch_inst[31]}}, fetch_inst[31:20]};
		case (fi.r.opcode)
			OP_R_TYPE: begin
				exp_opa = expect_fwd(fi.r.rs1);
				exp_opb = expect_fwd(fi.r.rs2);
			end
			OP_I_ARITH, OP_I_LOAD: begin
				exp_opa = expect_fwd(fi.r.rs1);
				exp_opb = SEL_IMM;
				exp_cmd = (fi.r.opcode == OP_I_LOAD) ? BUS_LOAD : BUS_NONE;
			end
			OP_S_TYPE: begin
				exp_opa = expect_fwd(fi.r.rs1);
				exp_opb = SEL_IMM;
				exp_cmd = BUS_STORE;
				exp_rd = ZERO_REG;
				exp_imm = {{20{fetch_inst[31]}}, fetch_inst[31:25], fetch_inst[11:7]};
			end
			OP_B_TYPE: begin
				exp_opa = SEL_PC;
				exp_opb = SEL_IMM;
				exp_rd = ZERO_REG;
				exp_imm = {{20{fetch_inst[31]}}, fetch_inst[7], fetch_inst[30:25],
					fetch_inst[11:8], 1'b0};
			end
			OP_I_JALR:
				exp_opa = SEL_PC;
			OP_J_TYPE: begin
				exp_opa = SEL_PC;
				exp_imm = {{12{fetch_inst[31]}}, fetch_inst[19:12], fetch_inst[20],
					fetch_inst[30:21], 1'b0};
			end
			OP_U_LUI, OP_U_AUIPC: begin
				exp_opa = (fi.r.opcode == OP_U_AUIPC) ? SEL_PC : SEL_0;
				exp_opb = SEL_IMM;
				exp_imm = {fetch_inst[31:12], 12'h000};
			end
			OP_I_BREAK:
				exp_rd = ZERO_REG;
			default:
				known = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		want_pc <= fetch_pc;
		want_imm <= exp_imm;
		want_rs1 <= fi.r.rs1;
		want_rs2 <= fi.r.rs2;
		want_rd <= exp_rd;
		want_opa <= exp_opa;
		want_opb <= exp_opb;
		want_alu <= alu_res[4:0];
		want_cmd <= exp_cmd;
		if (reset) begin
			want_vld <= 1'b0;
			hist1 <= ZERO_REG;
			hist2 <= ZERO_REG;
		end else begin
			want_vld <= exp_vld;
			hist1 <= exp_vld ? exp_rd : ZERO_REG;
			hist2 <= hist1;
		end
	end

	// **************************************************
	// issue outputs against the expected bundle
	// **************************************************
	a_vld: assert property (@(posedge clk) disable iff (reset) issue_vld == want_vld)
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: issue_vld is %0b, expected %0b",
				$time, $sampled(issue_vld), $sampled(want_vld));
		end

	a_pc: assert property (@(posedge clk) disable iff (reset) !want_vld || issue_pc == want_pc)
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: issue_pc is %h, expected %h",
				$time, $sampled(issue_pc), $sampled(want_pc));
		end

	a_imm: assert property (@(posedge clk) disable iff (reset)
		!want_vld || issue_imm == want_imm)
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: issue_imm is %h, expected %h",
				$time, $sampled(issue_imm), $sampled(want_imm));
		end

	a_rs1: assert property (@(posedge clk) disable iff (reset)
		!want_vld || issue_rs1 == want_rs1)
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: issue_rs1 is %0d, expected %0d",
				$time, $sampled(issue_rs1), $sampled(want_rs1));
		end

	a_rs2: assert property (@(posedge clk) disable iff (reset)
		!want_vld || issue_rs2 == want_rs2)
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: issue_rs2 is %0d, expected %0d",
				$time, $sampled(issue_rs2), $sampled(want_rs2));
		end

	a_rd: assert property (@(posedge clk) disable iff (reset) !want_vld || issue_rd == want_rd)
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: issue_rd is %0d, expected %0d",
				$time, $sampled(issue_rd), $sampled(want_rd));
		end

	a_opa: assert property (@(posedge clk) disable iff (reset)
		!want_vld || issue_opa_sel == want_opa)
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: issue_opa_sel is %0d, expected %0d",
				$time, $sampled(issue_opa_sel), $sampled(want_opa));
		end

	a_opb: assert property (@(posedge clk) disable iff (reset)
		!want_vld || issue_opb_sel == want_opb)
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: issue_opb_sel is %0d, expected %0d",
				$time, $sampled(issue_opb_sel), $sampled(want_opb));
		end

	a_alu: assert property (@(posedge clk) disable iff (reset)
		!want_vld || issue_alu_func == want_alu)
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: issue_alu_func is %0d, expected %0d",
				$time, $sampled(issue_alu_func), $sampled(want_alu));
		end

	a_cmd: assert property (@(posedge clk) disable iff (reset)
		!want_vld || issue_mem_cmd == want_cmd)
		else begin
			fail_count++;
			$error("CHECK FAILED at %0t: issue_mem_cmd is %0d, expected %0d",
				$time, $sampled(issue_mem_cmd), $sampled(want_cmd));
		end

endmodule

bind decode_top decode_asserts decode_asserts_inst (.*);

`default_nettype wire

//--- test/decode_tb.sv
`timescale 1ns/1ns
`default_nettype none

module decode_tb;

	import rv_decode_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int IDLE_LEN = 8;
	localparam int FMT_LEN = 200;
	localparam int ALU_LEN = 300;
	localparam int FWD_LEN = 200;
	localparam int PC_LEN = 100;
	// every phase ends with two empty slots and one settling edge
	localparam int RUN_CYCLES = RESET_CYCLES + IDLE_LEN + FMT_LEN + ALU_LEN + FWD_LEN
		+ PC_LEN + 5 * 3;

	logic			clk;
	logic			reset;
	logic	[31:0]	fetch_pc;
	logic	[31:0]	fetch_inst;
	logic			fetch_vld;
	logic			issue_vld;
	logic	[31:0]	issue_pc;
	logic	[31:0]	issue_imm;
	logic	[4:0]	issue_rs1;
	logic	[4:0]	issue_rs2;
	logic	[4:0]	issue_rd;
	logic	[2:0]	issue_opa_sel;
	logic	[2:0]	issue_opb_sel;
	logic	[4:0]	issue_alu_func;
	logic	[1:0]	issue_mem_cmd;

	logic	[31:0]	lfsr = 32'hefa1_4f4e;
	logic	[31:0]	next_pc;
	int				seen_fails;
	int				tests_run;
	int				tests_failed;

	decode_top decode_top_inst (
		.clk			(clk),
		.reset			(reset),
		.fetch_pc		(fetch_pc),
		.fetch_inst		(fetch_inst),
		.fetch_vld		(fetch_vld),
		.issue_vld		(issue_vld),
		.issue_pc		(issue_pc),
		.issue_imm		(issue_imm),
		.issue_rs1		(issue_rs1),
		.issue_rs2		(issue_rs2),
		.issue_rd		(issue_rd),
		.issue_opa_sel	(issue_opa_sel),
		.issue_opb_sel	(issue_opb_sel),
		.issue_alu_func	(issue_alu_func),
		.issue_mem_cmd	(issue_mem_cmd)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// taps 32, 22, 2 and 1 with one step per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic fb;
		int k;
		val = '0;
		for (k = 0; k < n; k++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic [6:0] op_class(input int idx);
		case (idx)
			0: return OP_R_TYPE;
			1: return OP_I_ARITH;
			2: return OP_I_LOAD;
			3: return OP_I_JALR;
			4: return OP_S_TYPE;
			5: return OP_B_TYPE;
			6: return OP_J_TYPE;
			7: return OP_U_LUI;
			8: return OP_U_AUIPC;
			default: return OP_I_BREAK;
		endcase
	endfunction

	task automatic drive(input logic [31:0] inst, input logic vld);
		@(posedge clk);
		fetch_inst <= inst;
		fetch_vld <= vld;
		fetch_pc <= next_pc;
		next_pc = next_pc + 32'd4;
	endtask

	task automatic close_test(input string name);
		int now_fails;
		drive(32'h0, 1'b0);
		drive(32'h0, 1'b0);
		@(negedge clk);
		now_fails = decode_top_inst.decode_asserts_inst.fail_count;
		$display("test %-12s %0d new failures", name, now_fails - seen_fails);
		if (now_fails != seen_fails)
			tests_failed++;
		seen_fails = now_fails;
		tests_run++;
	endtask

	// **************************************************
	// test phases
	// **************************************************
	task automatic idle_after_reset();
		logic [31:0] r;
		int n;
		for (n = 0; n < IDLE_LEN; n++) begin
			r = rand_bits(32);
			drive(r, 1'b0);
		end
		close_test("reset_idle");
	endtask

	task automatic sweep_formats();
		logic [31:0] r;
		int n;
		for (n = 0; n < FMT_LEN; n++) begin
			r = rand_bits(25);
			// R-type needs a clean funct7 to stay valid
			if (n % 10 == 0)
				r[24:18] = 7'h00;
			drive({r[24:0], op_class(n % 10)}, 1'b1);
		end
		close_test("formats");
	endtask

	task automatic alu_encodings();
		logic [31:0] sel;
		logic [31:0] body;
		logic [31:0] f7;
		logic [31:0] r;
		logic [6:0] op;
		int n;
		for (n = 0; n < ALU_LEN; n++) begin
			sel = rand_bits(5);
			body = rand_bits(18);
			case (sel[1:0])
				2'd0: f7 = 32'h00;
				2'd1: f7 = 32'h20;
				2'd2: f7 = 32'h01;
				default: f7 = rand_bits(7);
			endcase
			if (sel[4:2] == 3'd7) begin
				r = rand_bits(7);
				op = r[6:0];
			end else if (sel[4]) begin
				op = OP_I_ARITH;
			end else begin
				op = OP_R_TYPE;
			end
			drive({f7[6:0], body[17:0], op}, 1'b1);
		end
		close_test("alu_funct");
	endtask

	task automatic forwarding_chains();
		logic [31:0] pick;
		logic [31:0] r;
		logic [4:0] rd1;
		logic [4:0] rd2;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [6:0] f7;
		logic [6:0] op;
		int n;
		rd1 = ZERO_REG;
		rd2 = ZERO_REG;
		for (n = 0; n < FWD_LEN; n++) begin
			pick = rand_bits(8);
			r = rand_bits(18);
			case (pick[1:0])
				2'd0: rs1 = rd1;
				2'd1: rs1 = rd2;
				2'd2: rs1 = ZERO_REG;
				default: rs1 = r[12:8];
			endcase
			case (pick[3:2])
				2'd0: rs2 = rd1;
				2'd1: rs2 = rd2;
				2'd2: rs2 = ZERO_REG;
				default: rs2 = r[17:13];
			endcase
			// some predecessors are dropped or carry a bad funct7
			f7 = (pick[7:5] == 3'd1) ? 7'h7f : 7'h00;
			op = pick[4] ? OP_I_ARITH : OP_R_TYPE;
			drive({f7, rs2, rs1, r[7:5], r[4:0], op}, pick[7:5] != 3'd0);
			rd2 = rd1;
			rd1 = r[4:0];
		end
		close_test("forwarding");
	endtask

	task automatic pc_and_jumps();
		logic [31:0] pick;
		logic [31:0] r;
		logic [6:0] op;
		int n;
		for (n = 0; n < PC_LEN; n++) begin
			pick = rand_bits(4);
			if (pick[3]) begin
				r = rand_bits(30);
				next_pc = {r[29:0], 2'b00};
			end
			r = rand_bits(25);
			case (pick[2:0])
				3'd0, 3'd5: op = OP_J_TYPE;
				3'd1, 3'd6: op = OP_I_JALR;
				3'd2: op = OP_U_AUIPC;
				3'd3: op = OP_B_TYPE;
				default: op = OP_U_LUI;
			endcase
			drive({r[24:0], op}, 1'b1);
		end
		close_test("pc_jumps");
	endtask

	initial begin
		reset = 1'b1;
		fetch_pc = 32'h0;
		fetch_inst = 32'h0;
		fetch_vld = 1'b0;
		next_pc = 32'h0000_1000;
		seen_fails = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		idle_after_reset();
		sweep_formats();
		alu_encodings();
		forwarding_chains();
		pc_and_jumps();
		$display("%0d tests, %0d failed, %0d failed checks", tests_run, tests_failed,
			seen_fails);
		if (seen_fails == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial begin
		#(2 * RUN_CYCLES * 20);
		$display("timeout: the test phases did not finish within %0d ns", 2 * RUN_CYCLES * 20);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/alu_func_dec.sv
`timescale 1ns/1ns
`default_nettype none

module alu_func_dec (
	input	rv_decode_pkg::rv_inst_t	inst,
	output	logic	[4:0]				alu_func,
	output	logic						func_ok
);

	import rv_decode_pkg::*;

	always_comb begin
		alu_func = ALU_ADD;
		func_ok = 1'b1;

		if (inst.r.opcode == OP_R_TYPE) begin
			// keyed on {funct7, funct3}
			case ({inst.r.funct7, inst.r.funct3})
				10'b0000000_000:	alu_func = ALU_ADD;
				10'b0100000_000:	alu_func = ALU_SUB;
				10'b0000000_001:	alu_func = ALU_SLL;
				10'b0000000_010:	alu_func = ALU_SLT;
				10'b0000000_011:	alu_func = ALU_SLTU;
				10'b0000000_100:	alu_func = ALU_XOR;
				10'b0000000_101:	alu_func = ALU_SRL;
				10'b0100000_101:	alu_func = ALU_SRA;
				10'b0000000_110:	alu_func = ALU_OR;
				10'b0000000_111:	alu_func = ALU_AND;
				10'b0000001_000:	alu_func = ALU_MUL;
				10'b0000001_001:	alu_func = ALU_MULH;
				10'b0000001_010:	alu_func = ALU_MULHSU;
				10'b0000001_011:	alu_func = ALU_MULHU;
				default:			func_ok = 1'b0;
			endcase
		end

		if (inst.r.opcode == OP_I_ARITH) begin
			case (inst.i.funct3)
				3'b000:	alu_func = ALU_ADD;
				3'b001:	alu_func = ALU_SLL;
				3'b010:	alu_func = ALU_SLT;
				3'b011:	alu_func = ALU_SLTU;
				3'b100:	alu_func = ALU_XOR;
				// instruction bit 30 splits the right shifts
				3'b101:	alu_func = inst.r.funct7[5] ? ALU_SRA : ALU_SRL;
				3'b110:	alu_func = ALU_OR;
				3'b111:	alu_func = ALU_AND;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/decode_top.sv
`timescale 1ns/1ns
`default_nettype none

module decode_top (
	input	logic			clk,
	input	logic			reset,

	input	logic	[31:0]	fetch_pc,
	input	logic	[31:0]	fetch_inst,
	input	logic			fetch_vld,

	output	logic			issue_vld,
	output	logic	[31:0]	issue_pc,
	output	logic	[31:0]	issue_imm,
	output	logic	[4:0]	issue_rs1,
	output	logic	[4:0]	issue_rs2,
	output	logic	[4:0]	issue_rd,
	output	logic	[2:0]	issue_opa_sel,
	output	logic	[2:0]	issue_opb_sel,
	output	logic	[4:0]	issue_alu_func,
	output	logic	[1:0]	issue_mem_cmd
);

	logic	[31:0]	dec_pc;
	logic	[31:0]	dec_imm;
	logic	[4:0]	dec_rs1;
	logic	[4:0]	dec_rs2;
	logic	[4:0]	dec_rd;
	logic	[2:0]	dec_opa_sel;
	logic	[2:0]	dec_opb_sel;
	logic	[4:0]	dec_alu_func;
	logic	[1:0]	dec_mem_cmd;
	logic			dec_vld;
	// destination history fed back for forwarding
	logic	[4:0]	ex_rd;
	logic	[4:0]	mem_rd;

	id_stage id_stage_inst (
		.fetch_pc		(fetch_pc),
		.fetch_inst		(fetch_inst),
		.fetch_vld		(fetch_vld),
		.ex_rd			(ex_rd),
		.mem_rd			(mem_rd),
		.dec_pc			(dec_pc),
		.dec_imm		(dec_imm),
		.dec_rs1		(dec_rs1),
		.dec_rs2		(dec_rs2),
		.dec_rd			(dec_rd),
		.dec_opa_sel	(dec_opa_sel),
		.dec_opb_sel	(dec_opb_sel),
		.dec_alu_func	(dec_alu_func),
		.dec_mem_cmd	(dec_mem_cmd),
		.dec_vld		(dec_vld)
	);

	issue_reg issue_reg_inst (
		.clk			(clk),
		.reset			(reset),
		.dec_pc			(dec_pc),
		.dec_imm		(dec_imm),
		.dec_rs1		(dec_rs1),
		.dec_rs2		(dec_rs2),
		.dec_rd			(dec_rd),
		.dec_opa_sel	(dec_opa_sel),
		.dec_opb_sel	(dec_opb_sel),
		.dec_alu_func	(dec_alu_func),
		.dec_mem_cmd	(dec_mem_cmd),
		.dec_vld		(dec_vld),
		.issue_pc		(issue_pc),
		.issue_imm		(issue_imm),
		.issue_rs1		(issue_rs1),
		.issue_rs2		(issue_rs2),
		.issue_rd		(issue_rd),
		.issue_opa_sel	(issue_opa_sel),
		.issue_opb_sel	(issue_opb_sel),
		.issue_alu_func	(issue_alu_func),
		.issue_mem_cmd	(issue_mem_cmd),
		.issue_vld		(issue_vld),
		.ex_rd			(ex_rd),
		.mem_rd			(mem_rd)
	);

endmodule

`default_nettype wire

//--- verilog/id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage (
	input	logic	[31:0]	fetch_pc,
	input	logic	[31:0]	fetch_inst,
	input	logic			fetch_vld,
	input	logic	[4:0]	ex_rd,
	input	logic	[4:0]	mem_rd,

	output	logic	[31:0]	dec_pc,
	output	logic	[31:0]	dec_imm,
	output	logic	[4:0]	dec_rs1,
	output	logic	[4:0]	dec_rs2,
	output	logic	[4:0]	dec_rd,
	output	logic	[2:0]	dec_opa_sel,
	output	logic	[2:0]	dec_opb_sel,
	output	logic	[4:0]	dec_alu_func,
	output	logic	[1:0]	dec_mem_cmd,
	output	logic			dec_vld
);

	import rv_decode_pkg::*;

	rv_inst_t		inst;
	logic	[6:0]	opcode;
	logic			func_ok;
	logic			op_known;

	// the nearer instruction wins when both history entries match
	function automatic logic [2:0] fwd_sel(input logic [4:0] src, input logic [4:0] rd1,
		input logic [4:0] rd2);
		if (src == ZERO_REG)
			return SEL_0;
		else if (src == rd1)
			return SEL_F1;
		else if (src == rd2)
			return SEL_F2;
		else
			return SEL_RS;
	endfunction

	assign inst = fetch_inst;
	assign opcode = inst.r.opcode;

	assign dec_pc = fetch_pc;
	assign dec_rs1 = inst.r.rs1;
	assign dec_rs2 = inst.r.rs2;

	imm_gen imm_gen_inst (
		.inst	(inst),
		.imm	(dec_imm)
	);

	alu_func_dec alu_func_dec_inst (
		.inst		(inst),
		.alu_func	(dec_alu_func),
		.func_ok	(func_ok)
	);

	// **************************************************
	// operand selects
	// **************************************************
	always_comb begin
		case (opcode)
			OP_R_TYPE, OP_I_ARITH, OP_I_LOAD, OP_S_TYPE:
				dec_opa_sel = fwd_sel(dec_rs1, ex_rd, mem_rd);
			OP_I_JALR, OP_B_TYPE, OP_J_TYPE, OP_U_AUIPC:
				dec_opa_sel = SEL_PC;
			default:
				dec_opa_sel = SEL_0;
		endcase

		case (opcode)
			OP_R_TYPE:
				dec_opb_sel = fwd_sel(dec_rs2, ex_rd, mem_rd);
			OP_I_ARITH, OP_I_LOAD, OP_S_TYPE, OP_B_TYPE, OP_U_LUI, OP_U_AUIPC:
				dec_opb_sel = SEL_IMM;
			// jumps add four to the pc for the link value
			default:
				dec_opb_sel = SEL_4;
		endcase
	end

	// **************************************************
	// command, destination and validity
	// **************************************************
	always_comb begin
		case (opcode)
			OP_I_LOAD:	dec_mem_cmd = BUS_LOAD;
			OP_S_TYPE:	dec_mem_cmd = BUS_STORE;
			default:	dec_mem_cmd = BUS_NONE;
		endcase

		case (opcode)
			OP_S_TYPE, OP_B_TYPE, OP_I_BREAK:	dec_rd = ZERO_REG;
			default:							dec_rd = inst.r.rd;
		endcase

		case (opcode)
			OP_R_TYPE, OP_I_ARITH, OP_I_LOAD, OP_I_JALR, OP_S_TYPE,
			OP_B_TYPE, OP_J_TYPE, OP_U_LUI, OP_U_AUIPC, OP_I_BREAK:
				op_known = 1'b1;
			default:
				op_known = 1'b0;
		endcase
	end

	assign dec_vld = fetch_vld & op_known & func_ok;

endmodule

`default_nettype wire

//--- verilog/imm_gen.sv
`timescale 1ns/1ns
`default_nettype none

module imm_gen (
	input	rv_decode_pkg::rv_inst_t	inst,
	output	logic	[31:0]				imm
);

	import rv_decode_pkg::*;

	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_j;
	logic [31:0] imm_u;

	// every signed format takes its sign from instruction bit 31
	assign imm_i = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
	assign imm_s = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
	assign imm_b = {{20{inst.b.imm_12}}, inst.b.imm_11, inst.b.imm_10_5,
		inst.b.imm_4_1, 1'b0};
	assign imm_j = {{12{inst.j.imm_20}}, inst.j.imm_19_12, inst.j.imm_11,
		inst.j.imm_10_1, 1'b0};
	assign imm_u = {inst.u.imm_31_12, 12'b0};

	always_comb begin
		case (inst.r.opcode)
			OP_S_TYPE:				imm = imm_s;
			OP_B_TYPE:				imm = imm_b;
			OP_J_TYPE:				imm = imm_j;
			OP_U_LUI, OP_U_AUIPC:	imm = imm_u;
			default:				imm = imm_i;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/issue_reg.sv
`timescale 1ns/1ns
`default_nettype none

module issue_reg (
	input	logic			clk,
	input	logic			reset,

	input	logic	[31:0]	dec_pc,
	input	logic	[31:0]	dec_imm,
	input	logic	[4:0]	dec_rs1,
	input	logic	[4:0]	dec_rs2,
	input	logic	[4:0]	dec_rd,
	input	logic	[2:0]	dec_opa_sel,
	input	logic	[2:0]	dec_opb_sel,
	input	logic	[4:0]	dec_alu_func,
	input	logic	[1:0]	dec_mem_cmd,
	input	logic			dec_vld,

	output	logic	[31:0]	issue_pc,
	output	logic	[31:0]	issue_imm,
	output	logic	[4:0]	issue_rs1,
	output	logic	[4:0]	issue_rs2,
	output	logic	[4:0]	issue_rd,
	output	logic	[2:0]	issue_opa_sel,
	output	logic	[2:0]	issue_opb_sel,
	output	logic	[4:0]	issue_alu_func,
	output	logic	[1:0]	issue_mem_cmd,
	output	logic			issue_vld,
	output	logic	[4:0]	ex_rd,
	output	logic	[4:0]	mem_rd
);

	import rv_decode_pkg::*;

	always_ff @(posedge clk) begin
		issue_pc <= dec_pc;
		issue_imm <= dec_imm;
		issue_rs1 <= dec_rs1;
		issue_rs2 <= dec_rs2;
		issue_rd <= dec_rd;
		issue_opa_sel <= dec_opa_sel;
		issue_opb_sel <= dec_opb_sel;
		issue_alu_func <= dec_alu_func;
		issue_mem_cmd <= dec_mem_cmd;
	end

	// an invalid slot enters the history as x0 so it never forwards
	always_ff @(posedge clk) begin
		if (reset) begin
			issue_vld <= 1'b0;
			ex_rd <= ZERO_REG;
			mem_rd <= ZERO_REG;
		end else begin
			issue_vld <= dec_vld;
			ex_rd <= dec_vld ? dec_rd : ZERO_REG;
			mem_rd <= ex_rd;
		end
	end

endmodule

`default_nettype wire

//--- verilog/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

	// **************************************************
	// one opcode per instruction class
	// **************************************************
	localparam logic [6:0] OP_R_TYPE  = 7'b0110011;
	localparam logic [6:0] OP_I_ARITH = 7'b0010011;
	localparam logic [6:0] OP_I_LOAD  = 7'b0000011;
	localparam logic [6:0] OP_I_JALR  = 7'b1100111;
	localparam logic [6:0] OP_S_TYPE  = 7'b0100011;
	localparam logic [6:0] OP_B_TYPE  = 7'b1100011;
	localparam logic [6:0] OP_J_TYPE  = 7'b1101111;
	localparam logic [6:0] OP_U_LUI   = 7'b0110111;
	localparam logic [6:0] OP_U_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_I_BREAK = 7'b1110011;

	localparam logic [4:0] ZERO_REG = 5'd0;

	// where an ALU operand comes from
	localparam logic [2:0] SEL_0   = 3'd0;
	localparam logic [2:0] SEL_RS  = 3'd1;
	localparam logic [2:0] SEL_F1  = 3'd2;
	localparam logic [2:0] SEL_F2  = 3'd3;
	localparam logic [2:0] SEL_PC  = 3'd4;
	localparam logic [2:0] SEL_IMM = 3'd5;
	localparam logic [2:0] SEL_4   = 3'd6;

	// execute operations with the M extension after the base set
	localparam logic [4:0] ALU_ADD    = 5'd0;
	localparam logic [4:0] ALU_SUB    = 5'd1;
	localparam logic [4:0] ALU_XOR    = 5'd2;
	localparam logic [4:0] ALU_OR     = 5'd3;
	localparam logic [4:0] ALU_AND    = 5'd4;
	localparam logic [4:0] ALU_SLL    = 5'd5;
	localparam logic [4:0] ALU_SRL    = 5'd6;
	localparam logic [4:0] ALU_SRA    = 5'd7;
	localparam logic [4:0] ALU_SLT    = 5'd8;
	localparam logic [4:0] ALU_SLTU   = 5'd9;
	localparam logic [4:0] ALU_MUL    = 5'd10;
	localparam logic [4:0] ALU_MULH   = 5'd11;
	localparam logic [4:0] ALU_MULHSU = 5'd12;
	localparam logic [4:0] ALU_MULHU  = 5'd13;

	localparam logic [1:0] BUS_NONE  = 2'd0;
	localparam logic [1:0] BUS_LOAD  = 2'd1;
	localparam logic [1:0] BUS_STORE = 2'd2;

	// **************************************************
	// instruction formats laid over the same word
	// **************************************************
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} rv_i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} rv_s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} rv_b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} rv_u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_j_fmt_t;

	typedef union packed {
		rv_r_fmt_t r;
		rv_i_fmt_t i;
		rv_s_fmt_t s;
		rv_b_fmt_t b;
		rv_u_fmt_t u;
		rv_j_fmt_t j;
	} rv_inst_t;

endpackage

`default_nettype wire
